// ==== verilog.f ====
verilog/ramio_pkg.sv
verilog/bus_decode.sv
verilog/word_ram.sv
verilog/uart_regs.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/ramio_top.sv
tb/tb_clock.sv
tb/ramio_checker.sv
tb/ramio_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the RAM/UART client port testbench with Verilator and run it
# fails on a build error, a nonzero simulator exit or the fail message in the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timing --top-module ramio_tb -f verilog.f -o ramio_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ramio_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
  exit 1
fi
exit 0

// ==== tb/ramio_tb.sv ====
// directed tests for the RAM and UART client port, UART pins looped back
// stimulus moves on the falling edge, outputs are sampled a quarter period later
// the UART in test runs before the UART out test so UART in starts empty

`timescale 1ns/100ps

module ramio_tb;

  localparam int clk_period   = 100;
  localparam int frame_cycles = 10 * ramio_pkg::clks_per_bit;
  // four UART frames plus the RAM tests
  localparam int timeout_cycles = 4 * frame_cycles + 360;
  localparam logic [31:0] ext_pattern = 32'h80ff_7f01;

  logic                         clk;
  logic                         rst_n;
  logic                         enable;
  logic [2:0]                   read_type;
  logic [1:0]                   write_type;
  logic [ramio_pkg::addr_w-1:0] address;
  logic [ramio_pkg::data_w-1:0] data_in;
  logic [ramio_pkg::data_w-1:0] data_out;
  logic                         data_out_ready;
  logic                         serial_line;
  logic [3:0]                   led;

  string test_name;
  int    test_errors  = 0;
  int    total_errors = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    cycles       = 0;
  // leds seen at the same instant as the read data
  logic [3:0] led_at_read;

  tb_clock #(.period(clk_period), .reset_cycles(3)) u_clock (.clk, .rst_n);

  ramio_top DUT (
    .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .uart_tx(serial_line), .uart_rx(serial_line), .led
  );

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // bus helpers
  // --------------------------------------------------
  task automatic release_bus();
    enable     = 1'b0;
    read_type  = ramio_pkg::rd_none;
    write_type = ramio_pkg::wr_none;
    address    = '0;
    data_in    = '0;
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
      test_errors++;
    end
  endtask

  // one write cycle, taken at the rising edge in between
  task automatic bus_write(input logic [31:0] addr, input logic [1:0] wtype,
                           input logic [31:0] data);
    @(negedge clk);
    enable     = 1'b1;
    address    = addr;
    write_type = wtype;
    data_in    = data;
    @(negedge clk);
    release_bus();
  endtask

  // holds the read until data_out_ready, at most two cycles
  task automatic bus_read(input logic [31:0] addr, input logic [2:0] rtype,
                          output logic [31:0] value);
    int waited;
    @(negedge clk);
    enable    = 1'b1;
    address   = addr;
    read_type = rtype;
    waited    = 0;
    #(clk_period / 4);
    while (data_out_ready !== 1'b1 && waited < 2) begin
      @(negedge clk);
      #(clk_period / 4);
      waited++;
    end
    assert (data_out_ready === 1'b1) else begin
      $display("%s: data_out_ready not seen within two cycles of a read at %h",
               test_name, addr);
      test_errors++;
    end
    value       = data_out;
    led_at_read = led;
    @(negedge clk);
    release_bus();
  endtask

  // polls UART out until the frame is done, every busy value must be the byte sent
  task automatic wait_tx_idle(input logic [7:0] sent);
    logic [31:0] value;
    logic        done;
    done = 1'b0;
    while (!done) begin
      bus_read(ramio_pkg::addr_uart_out, ramio_pkg::rd_word, value);
      if (value === ramio_pkg::uart_idle) begin
        done = 1'b1;
      end else begin
        check_value({24'h0, sent}, value);
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, test_errors);
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic word_write_read();
    logic [31:0] addrs [8];
    logic [31:0] words [8];
    logic [31:0] value;
    begin_test("word write and read back");
    // one word index in each block of 32, so no two collide
    for (int i = 0; i < 8; i++) begin
      addrs[i] = {22'h0, 8'(i * 32 + int'($urandom_range(31, 0))), 2'b00};
      words[i] = $urandom;
      bus_write(addrs[i], ramio_pkg::wr_word, words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(addrs[i], ramio_pkg::rd_word, value);
      check_value(words[i], value);
    end
    end_test();
  endtask

  task automatic partial_writes();
    logic [31:0] base_addr;
    logic [31:0] model;
    logic [31:0] value;
    logic [7:0]  b;
    logic [15:0] h;
    begin_test("byte and half-word writes");
    base_addr = 32'h0000_0100;
    model     = $urandom;
    bus_write(base_addr, ramio_pkg::wr_word, model);
    // upper data bits are junk and must not reach memory
    for (int off = 0; off < 4; off++) begin
      b = 8'($urandom);
      bus_write(base_addr + 32'(off), ramio_pkg::wr_byte, {24'($urandom), b});
      model = (model & ~(32'h0000_00ff << (8 * off))) | ({24'h0, b} << (8 * off));
      bus_read(base_addr, ramio_pkg::rd_word, value);
      check_value(model, value);
    end
    for (int off = 0; off < 4; off += 2) begin
      h = 16'($urandom);
      bus_write(base_addr + 32'(off), ramio_pkg::wr_half, {16'($urandom), h});
      model = (model & ~(32'h0000_ffff << (8 * off))) | ({16'h0, h} << (8 * off));
      bus_read(base_addr, ramio_pkg::rd_word, value);
      check_value(model, value);
    end
    end_test();
  endtask

  task automatic extension_reads();
    logic [31:0] addr;
    logic [31:0] lane;
    logic [31:0] expected;
    logic [31:0] value;
    logic [2:0]  signed_flag;
    begin_test("sign and zero extension");
    signed_flag = 3'(1 << ramio_pkg::rd_signed_bit);
    addr        = 32'h0000_0200;
    bus_write(addr, ramio_pkg::wr_word, ext_pattern);
    for (int off = 0; off < 4; off++) begin
      lane = (ext_pattern >> (8 * off)) & 32'h0000_00ff;
      bus_read(addr + 32'(off), ramio_pkg::rd_byte, value);
      check_value(lane, value);
      expected = lane[7] ? (lane | 32'hffff_ff00) : lane;
      bus_read(addr + 32'(off), ramio_pkg::rd_byte | signed_flag, value);
      check_value(expected, value);
    end
    for (int off = 0; off < 4; off += 2) begin
      lane = (ext_pattern >> (8 * off)) & 32'h0000_ffff;
      bus_read(addr + 32'(off), ramio_pkg::rd_half, value);
      check_value(lane, value);
      expected = lane[15] ? (lane | 32'hffff_0000) : lane;
      bus_read(addr + 32'(off), ramio_pkg::rd_half | signed_flag, value);
      check_value(expected, value);
    end
    end_test();
  endtask

  task automatic uart_in_loopback();
    logic [31:0] value;
    logic [7:0]  b;
    logic        got;
    logic        line_low_seen;
    begin_test("UART in via loopback");
    bus_read(ramio_pkg::addr_uart_in, ramio_pkg::rd_word, value);
    check_value(ramio_pkg::uart_idle, value);
    // idle line, nothing pending and led[2] off, so every led is dark
    check_value(32'hf, {28'h0, led_at_read});
    b = 8'($urandom);
    bus_write(ramio_pkg::addr_uart_out, ramio_pkg::wr_byte, {24'h0, b});
    // led[3] is lit (low) only while a byte waits
    got           = 1'b0;
    line_low_seen = 1'b0;
    while (!got) begin
      bus_read(ramio_pkg::addr_uart_in, ramio_pkg::rd_word, value);
      // the start bit on the looped-back line lights led[1:0]
      if (led_at_read[1:0] == 2'b00) begin
        line_low_seen = 1'b1;
      end
      check_value(32'h1, {31'h0, led_at_read[2]});
      if (value !== ramio_pkg::uart_idle) begin
        got = 1'b1;
        check_value({24'h0, b}, value);
        check_value(32'h0, {31'h0, led_at_read[3]});
      end else begin
        check_value(32'h1, {31'h0, led_at_read[3]});
      end
    end
    assert (line_low_seen) else begin
      $display("%s: led[1:0] never showed the serial line low", test_name);
      test_errors++;
    end
    // that read emptied UART in
    check_value(32'h1, {31'h0, led[3]});
    bus_read(ramio_pkg::addr_uart_in, ramio_pkg::rd_word, value);
    check_value(ramio_pkg::uart_idle, value);
    wait_tx_idle(b);
    end_test();
  endtask

  task automatic uart_out_register();
    logic [31:0] value;
    logic [7:0]  b;
    begin_test("UART out register");
    b = 8'($urandom);
    bus_write(ramio_pkg::addr_uart_out, ramio_pkg::wr_byte, {24'($urandom), b});
    bus_read(ramio_pkg::addr_uart_out, ramio_pkg::rd_word, value);
    check_value({24'h0, b}, value);
    wait_tx_idle(b);
    end_test();
  endtask

  // --------------------------------------------------
  initial begin
    void'($urandom(10));
    release_bus();
    wait (rst_n === 1'b1);
    word_write_read();
    partial_writes();
    extension_reads();
    uart_in_loopback();
    uart_out_register();
    total_errors += DUT.u_checker.fail_count;
    $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, DUT.u_checker.fail_count);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/ramio_checker.sv ====
// concurrent checks on the client port, bound into ramio_top
// tx_go and tx_bsy are taken from inside the top level
// fail_count tallies the failed assertions for the closing summary

`timescale 1ns/100ps

module ramio_checker (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         enable,
  input logic [2:0]                   read_type,
  input logic [ramio_pkg::addr_w-1:0] address,
  input logic                         data_out_ready,
  input logic                         uart_tx,
  input logic                         tx_go,
  input logic                         tx_bsy
);

  int   fail_count = 0;
  logic in_reset_d = 1'b0;
  logic io_addr;

  assign io_addr = address == ramio_pkg::addr_uart_out ||
                   address == ramio_pkg::addr_uart_in ||
                   address == ramio_pkg::addr_led;

  // reset seen on the previous edge, so the line has been reset once
  always_ff @(posedge clk) in_reset_d <= !rst_n;

  // --------------------------------------------------
  // I/O reads answer in the same cycle
  io_read_ready: assert property (@(posedge clk) disable iff (!rst_n)
    enable && io_addr && read_type != ramio_pkg::rd_none |-> data_out_ready)
  else begin
    fail_count++;
    $error("data_out_ready low during an I/O read");
  end

  // serial line idles high while reset is held
  tx_idle_in_reset: assert property (@(posedge clk)
    !rst_n && in_reset_d |-> uart_tx)
  else begin
    fail_count++;
    $error("uart_tx not high during reset");
  end

  // a new frame is only requested when the transmitter is free
  go_not_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(tx_go) |-> !tx_bsy)
  else begin
    fail_count++;
    $error("tx_go rose while tx_bsy was high");
  end

endmodule

bind ramio_top ramio_checker u_checker (
  .clk, .rst_n, .enable, .read_type, .address, .data_out_ready, .uart_tx, .tx_go, .tx_bsy
);

// ==== tb/tb_clock.sv ====
// clock and synchronous reset for the testbench
// reset is held low over the first reset_cycles rising edges, released on a falling edge

`timescale 1ns/100ps

module tb_clock #(
  parameter int period       = 100,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== verilog/ramio_top.sv ====
// top of the client port: one request port to a local word RAM and a UART
// no handshake, a request is the enable level with read_type or write_type
// led outputs are active low, led[2] is held off

`timescale 1ns/100ps

module ramio_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          enable,
  input  logic [2:0]                    read_type,
  input  logic [1:0]                    write_type,
  input  logic [ramio_pkg::addr_w-1:0]  address,
  input  logic [ramio_pkg::data_w-1:0]  data_in,
  output logic [ramio_pkg::data_w-1:0]  data_out,
  output logic                          data_out_ready,
  output logic                          uart_tx,
  input  logic                          uart_rx,
  output logic [3:0]                    led
);

  // --------------------------------------------------
  // decoder to RAM
  // --------------------------------------------------
  logic                 ram_en;
  logic [3:0]           ram_we;
  ramio_pkg::ram_word_u ram_wdata;
  ramio_pkg::ram_word_u ram_rdata;
  logic                 ram_ready;

  // decoder to UART registers
  logic                         uart_out_wr;
  logic [7:0]                   uart_out_byte;
  logic                         uart_in_rd;
  logic [ramio_pkg::data_w-1:0] tx_word;
  logic [ramio_pkg::data_w-1:0] rx_word;

  // UART registers to the serial blocks
  logic       tx_go;
  logic [7:0] tx_byte;
  logic       tx_bsy;
  logic       rx_go;
  logic [7:0] rx_data;
  logic       rx_ready;
  logic       rx_pending;

  // pins mirrored on the LEDs, low means lit
  assign led[0] = uart_tx;
  assign led[1] = uart_rx;
  assign led[2] = 1'b1;
  assign led[3] = !rx_pending;

  bus_decode u_decode (
    .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready,
    .ram_en, .ram_we, .ram_wdata, .ram_rdata, .ram_ready,
    .uart_out_wr, .uart_out_byte, .uart_in_rd, .tx_word, .rx_word
  );

  word_ram u_ram (
    .clk, .rst_n, .ram_en, .ram_we, .address, .ram_wdata, .ram_rdata, .ram_ready
  );

  uart_regs u_regs (
    .clk, .rst_n, .uart_out_wr, .uart_out_byte, .uart_in_rd, .tx_word, .rx_word,
    .tx_go, .tx_byte, .tx_bsy, .rx_go, .rx_data, .rx_ready, .rx_pending
  );

  uart_tx u_tx (
    .clk, .rst_n, .tx_go, .tx_byte, .tx_bsy, .uart_tx
  );

  uart_rx u_rx (
    .clk, .rst_n, .rx_go, .uart_rx, .rx_data, .rx_ready
  );

endmodule

// ==== verilog/uart_rx.sv ====
// 8N1 serial receiver, samples each bit at mid-bit after a two-flop synchronizer
// rx_ready holds until rx_go drops, no new frame is started meanwhile
// a start bit that is gone at mid-bit is taken as noise, the stop bit is not checked

`timescale 1ns/100ps

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_go,
  input  logic       uart_rx,
  output logic [7:0] rx_data,
  output logic       rx_ready
);

  logic [1:0]                   sync;
  logic                         line;
  logic                         busy;
  logic [3:0]                   bit_cnt;
  logic [ramio_pkg::baud_w-1:0] baud_cnt;
  logic [ramio_pkg::baud_w-1:0] bit_last;
  logic                         tick;

  assign line = sync[1];

  // half a bit to reach the middle of the start bit, then full bits
  assign bit_last = (bit_cnt == 4'd0) ?
                    ramio_pkg::baud_w'(ramio_pkg::clks_per_bit / 2 - 1) :
                    ramio_pkg::baud_w'(ramio_pkg::clks_per_bit - 1);
  assign tick = busy && baud_cnt == bit_last;

  // data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (tick && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
      rx_data <= {line, rx_data[7:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync     <= 2'b11;
      busy     <= 1'b0;
      rx_ready <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else begin
      sync <= {sync[0], uart_rx};
      // acknowledge from the register block
      if (!rx_go) rx_ready <= 1'b0;

      if (!busy) begin
        // falling edge on an idle line starts a frame
        if (rx_go && !rx_ready && !line) begin
          busy     <= 1'b1;
          bit_cnt  <= '0;
          baud_cnt <= '0;
        end
      end else if (tick) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd0 && line) begin
          busy <= 1'b0;
        end else if (bit_cnt == 4'd9) begin
          busy     <= 1'b0;
          rx_ready <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/uart_tx.sv ====
// 8N1 serial transmitter, LSB first, clks_per_bit clocks per bit
// tx_go starts a frame, tx_bsy falls after the stop bit
// no new frame until tx_go has been dropped as the acknowledge

`timescale 1ns/100ps

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_go,
  input  logic [7:0] tx_byte,
  output logic       tx_bsy,
  output logic       uart_tx
);

  logic [8:0]                   frame;
  logic [3:0]                   bit_cnt;
  logic [ramio_pkg::baud_w-1:0] baud_cnt;
  logic                         wait_ack;
  logic                         start;
  logic                         bit_end;

  assign start   = tx_go && !tx_bsy && !wait_ack;
  assign bit_end = tx_bsy && baud_cnt == ramio_pkg::baud_w'(ramio_pkg::clks_per_bit - 1);

  // data bits then stop bit, shifted out at each bit boundary
  always_ff @(posedge clk) begin
    if (start) begin
      frame <= {1'b1, tx_byte};
    end else if (bit_end) begin
      frame <= {1'b1, frame[8:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uart_tx  <= 1'b1;
      tx_bsy   <= 1'b0;
      wait_ack <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else if (start) begin
      // start bit
      uart_tx  <= 1'b0;
      tx_bsy   <= 1'b1;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else if (tx_bsy) begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      if (bit_end) begin
        // bit 9 is the stop bit, line is already high
        if (bit_cnt == 4'd9) begin
          tx_bsy   <= 1'b0;
          wait_ack <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          uart_tx <= frame[0];
        end
      end
    end else if (wait_ack && !tx_go) begin
      wait_ack <= 1'b0;
    end
  end

endmodule

// ==== verilog/uart_regs.sv ====
// UART out and UART in registers, all ones means empty
// a second out write while sending replaces the data, an unread byte is overwritten
// a continuous UART in read holds off the capture of a new byte

`timescale 1ns/100ps

module uart_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          uart_out_wr,
  input  logic [7:0]                    uart_out_byte,
  input  logic                          uart_in_rd,
  output logic [ramio_pkg::data_w-1:0]  tx_word,
  output logic [ramio_pkg::data_w-1:0]  rx_word,
  output logic                          tx_go,
  output logic [7:0]                    tx_byte,
  input  logic                          tx_bsy,
  output logic                          rx_go,
  input  logic [7:0]                    rx_data,
  input  logic                          rx_ready,
  output logic                          rx_pending
);

  // high for the cycle after tx_go is raised, before tx_bsy can follow
  logic tx_go_new;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_word   <= ramio_pkg::uart_idle;
      tx_go     <= 1'b0;
      tx_go_new <= 1'b0;
      rx_word   <= ramio_pkg::uart_idle;
      rx_go     <= 1'b1;
    end else begin
      tx_go_new <= 1'b0;

      // --------------------------------------------------
      // receive side
      // --------------------------------------------------
      // reading UART in empties it, this wins over a new byte
      if (uart_in_rd) begin
        rx_word <= ramio_pkg::uart_idle;
      end else if (rx_go && rx_ready) begin
        rx_word <= {24'h00_0000, rx_data};
        rx_go   <= 1'b0;
      end
      // one low cycle on rx_go acknowledges the byte
      if (!rx_go) rx_go <= 1'b1;

      // --------------------------------------------------
      // transmit side
      // --------------------------------------------------
      // frame finished, drop go as the acknowledge and go idle
      if (tx_go && !tx_bsy && !tx_go_new) begin
        tx_go   <= 1'b0;
        tx_word <= ramio_pkg::uart_idle;
      end
      // write to UART out starts a frame
      if (uart_out_wr) begin
        tx_word   <= {24'h00_0000, uart_out_byte};
        tx_go     <= 1'b1;
        tx_go_new <= 1'b1;
      end
    end
  end

  assign tx_byte    = tx_word[7:0];
  assign rx_pending = rx_word != ramio_pkg::uart_idle;

endmodule

// ==== verilog/word_ram.sv ====
// byte-enabled word RAM with a registered read and no stall
// ram_ready stays high while the same word index is requested in a read

`timescale 1ns/100ps

module word_ram (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ram_en,
  input  logic [3:0]                    ram_we,
  input  logic [ramio_pkg::addr_w-1:0]  address,
  input  ramio_pkg::ram_word_u          ram_wdata,
  output ramio_pkg::ram_word_u          ram_rdata,
  output logic                          ram_ready
);

  ramio_pkg::ram_word_u mem [ramio_pkg::ram_words];

  logic [ramio_pkg::ram_idx_w-1:0] idx;
  logic [ramio_pkg::ram_idx_w-1:0] rd_idx;
  logic                            rd_valid;
  logic                            rd_req;

  // word index from address bits 9:2
  assign idx    = address[ramio_pkg::ram_idx_w+1:2];
  assign rd_req = ram_en && ram_we == 4'b0000;

  // storage and read data
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_we[i]) mem[idx].bytes[i] <= ram_wdata.bytes[i];
      end
      ram_rdata <= mem[idx];
    end
    rd_idx <= idx;
  end

  // a read seen on the last edge makes the word valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_req;
    end
  end

  assign ram_ready = rd_valid && rd_req && rd_idx == idx;

endmodule

// ==== verilog/bus_decode.sv ====
// address decode, write lane steering and read extraction, all combinational
// misaligned half-word writes are dropped and misaligned half-word reads give zero
// word accesses ignore address bits 1:0

`timescale 1ns/100ps

module bus_decode (
  input  logic                          enable,
  input  logic [2:0]                    read_type,
  input  logic [1:0]                    write_type,
  input  logic [ramio_pkg::addr_w-1:0]  address,
  input  logic [ramio_pkg::data_w-1:0]  data_in,
  output logic [ramio_pkg::data_w-1:0]  data_out,
  output logic                          data_out_ready,
  output logic                          ram_en,
  output logic [3:0]                    ram_we,
  output ramio_pkg::ram_word_u          ram_wdata,
  input  ramio_pkg::ram_word_u          ram_rdata,
  input  logic                          ram_ready,
  output logic                          uart_out_wr,
  output logic [7:0]                    uart_out_byte,
  output logic                          uart_in_rd,
  input  logic [ramio_pkg::data_w-1:0]  tx_word,
  input  logic [ramio_pkg::data_w-1:0]  rx_word
);

  logic is_uart_out;
  logic is_uart_in;
  logic is_led;
  logic is_io;
  logic rd_req;
  logic wr_req;

  // lane picked out of the registered RAM word
  logic [7:0]                   sel_byte;
  logic [15:0]                  sel_half;
  logic                         sign_ext;
  logic [ramio_pkg::data_w-1:0] ram_value;

  // --------------------------------------------------
  // address map
  // --------------------------------------------------
  assign is_uart_out = address == ramio_pkg::addr_uart_out;
  assign is_uart_in  = address == ramio_pkg::addr_uart_in;
  assign is_led      = address == ramio_pkg::addr_led;
  assign is_io       = is_uart_out || is_uart_in || is_led;

  assign rd_req = read_type != ramio_pkg::rd_none;
  assign wr_req = write_type != ramio_pkg::wr_none;

  // everything outside the I/O map goes to RAM
  assign ram_en = enable && !is_io && (rd_req || wr_req);

  // UART register strobes, LED writes are accepted and dropped
  assign uart_out_wr   = enable && is_uart_out && wr_req;
  assign uart_out_byte = data_in[7:0];
  assign uart_in_rd    = enable && is_uart_in && rd_req;

  // I/O answers at once, RAM once the registered read matches the request
  assign data_out_ready = is_io ? 1'b1 : ram_ready;

  // --------------------------------------------------
  // write steering into byte lanes
  // --------------------------------------------------
  always_comb begin
    ram_we    = '0;
    ram_wdata = '0;
    if (ram_en) begin
      case (write_type)
        ramio_pkg::wr_byte: begin
          ram_we[address[1:0]]          = 1'b1;
          ram_wdata.bytes[address[1:0]] = data_in[7:0];
        end
        ramio_pkg::wr_half: begin
          // half word only on an even half boundary
          if (!address[0]) begin
            ram_we[{address[1], 1'b0} +: 2] = 2'b11;
            ram_wdata.halves[address[1]]    = data_in[15:0];
          end
        end
        ramio_pkg::wr_word: begin
          ram_we         = 4'b1111;
          ram_wdata.word = data_in;
        end
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // read extraction
  // --------------------------------------------------
  assign sel_byte = ram_rdata.bytes[address[1:0]];
  assign sel_half = ram_rdata.halves[address[1]];
  assign sign_ext = read_type[ramio_pkg::rd_signed_bit];

  always_comb begin
    case (read_type[1:0])
      ramio_pkg::rd_byte[1:0]: ram_value = {{24{sign_ext && sel_byte[7]}}, sel_byte};
      ramio_pkg::rd_half[1:0]: begin
        if (address[0]) begin
          ram_value = '0;
        end else begin
          ram_value = {{16{sign_ext && sel_half[15]}}, sel_half};
        end
      end
      ramio_pkg::rd_word[1:0]: ram_value = ram_rdata.word;
      default:                 ram_value = '0;
    endcase
  end

  // UART words are returned whole, whatever the read size
  always_comb begin
    data_out = '0;
    if (enable && rd_req) begin
      if (is_uart_out) begin
        data_out = tx_word;
      end else if (is_uart_in) begin
        data_out = rx_word;
      end else if (!is_led) begin
        data_out = ram_value;
      end
    end
  end

endmodule

// ==== verilog/ramio_pkg.sv ====
// shared constants and types for the memory-mapped RAM and UART client port
// the I/O addresses sit at the top of the 32-bit space and anything else is RAM
// the RAM index only uses address bits 9:2, so higher RAM addresses alias

package ramio_pkg;

  // --------------------------------------------------
  // client bus widths
  // --------------------------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // RAM depth in words, word index taken from address[9:2]
  localparam int ram_words = 256;
  localparam int ram_idx_w = $clog2(ram_words);

  // --------------------------------------------------
  // I/O address map
  // --------------------------------------------------
  localparam logic [addr_w-1:0] addr_led      = 32'hffff_fffc;
  localparam logic [addr_w-1:0] addr_uart_out = 32'hffff_fff8;
  localparam logic [addr_w-1:0] addr_uart_in  = 32'hffff_fff4;

  // read_type codes
  // bit 2 selects sign extension, low bits give the access size
  localparam logic [2:0] rd_none = 3'b000;
  localparam logic [2:0] rd_byte = 3'b001;
  localparam logic [2:0] rd_half = 3'b010;
  localparam logic [2:0] rd_word = 3'b011;
  localparam int rd_signed_bit = 2;

  // write_type codes
  localparam logic [1:0] wr_none = 2'b00;
  localparam logic [1:0] wr_byte = 2'b01;
  localparam logic [1:0] wr_half = 2'b10;
  localparam logic [1:0] wr_word = 2'b11;

  // all ones means nothing sending or nothing received
  localparam logic [data_w-1:0] uart_idle = '1;

  // --------------------------------------------------
  // UART timing
  // --------------------------------------------------
  localparam int clks_per_bit = 16;
  localparam int baud_w = $clog2(clks_per_bit);

  // one RAM word, seen whole, as byte lanes or as half-word lanes
  // lane 0 is the least significant
  typedef union packed {
    logic [31:0]       word;
    logic [3:0][7:0]   bytes;
    logic [1:0][15:0]  halves;
  } ram_word_u;

endpackage
